// ==== tb.f ====
+incdir+include
design/mem_msg_pkg.sv
design/net_msg_pkg.sv
design/mem_port_adapter.sv
design/mem_access_ctrl.sv
design/ring_net.sv
design/mem_net_top.sv
testbench/mem_net_checker.sv
testbench/tb_mem_net.sv

// ==== Makefile ====
# Verilator build and run for the secure memory network testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_net
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TEST PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) include/mem_net_config.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(SIM) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_mem_net.sv ====
/*
 * Secure memory network testbench: random traffic on both ports and
 * two bank models that answer every request
 */

`default_nettype none

`include "mem_net_config.svh"

module tb_mem_net
	import mem_msg_pkg::*;
	import net_msg_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int        reqs_per_port = 300;
	localparam int        cycle_limit   = 2 * reqs_per_port * 8 + 100;
	localparam mem_data_t rd_key        = 32'h5a5a_0f0f;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        mode;
	logic        finish;
	logic [31:0] seed = 32'h047f_0137;

	mem_req_t   req_in [2];
	logic [1:0] req_in_domain, req_in_de_nsb, req_in_val, resp_out_rdy;
	logic [1:0] req_out_rdy, resp_in_val;
	net_resp_t  resp_in [2];
	mem_resp_t  resp_out [2];
	net_req_t   req_out [2];
	wire  [1:0] req_in_rdy, resp_out_domain, resp_out_fail, resp_out_val;
	wire  [1:0] req_out_val, resp_in_rdy;
	int         pending;
	int         err_total;

	always #20 clk = ~clk;

	mem_net_top mem_net_top_inst (
		.clk                (clk),
		.rst_n              (rst_n),
		.mode               (mode),
		.req_in_p0          (req_in[0]),
		.req_in_domain_p0   (req_in_domain[0]),
		.req_in_de_nsb_p0   (req_in_de_nsb[0]),
		.req_in_val_p0      (req_in_val[0]),
		.req_in_rdy_p0      (req_in_rdy[0]),
		.resp_out_p0        (resp_out[0]),
		.resp_out_domain_p0 (resp_out_domain[0]),
		.resp_out_fail_p0   (resp_out_fail[0]),
		.resp_out_val_p0    (resp_out_val[0]),
		.resp_out_rdy_p0    (resp_out_rdy[0]),
		.req_in_p1          (req_in[1]),
		.req_in_domain_p1   (req_in_domain[1]),
		.req_in_de_nsb_p1   (req_in_de_nsb[1]),
		.req_in_val_p1      (req_in_val[1]),
		.req_in_rdy_p1      (req_in_rdy[1]),
		.resp_out_p1        (resp_out[1]),
		.resp_out_domain_p1 (resp_out_domain[1]),
		.resp_out_fail_p1   (resp_out_fail[1]),
		.resp_out_val_p1    (resp_out_val[1]),
		.resp_out_rdy_p1    (resp_out_rdy[1]),
		.req_out_p0         (req_out[0]),
		.req_out_val_p0     (req_out_val[0]),
		.req_out_rdy_p0     (req_out_rdy[0]),
		.resp_in_p0         (resp_in[0]),
		.resp_in_val_p0     (resp_in_val[0]),
		.resp_in_rdy_p0     (resp_in_rdy[0]),
		.req_out_p1         (req_out[1]),
		.req_out_val_p1     (req_out_val[1]),
		.req_out_rdy_p1     (req_out_rdy[1]),
		.resp_in_p1         (resp_in[1]),
		.resp_in_val_p1     (resp_in_val[1]),
		.resp_in_rdy_p1     (resp_in_rdy[1])
	);

	mem_net_checker #(.rd_key(rd_key)) checker_inst (.*);

	function logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// bank model, fails any compacted address with bit 3 set
	function automatic net_resp_t bank_answer(net_req_t q);
		net_resp_t a;
		a.dest        = q.src;
		a.domain      = q.domain;
		a.fail        = q.req.addr[3];
		a.resp.mtype  = q.req.mtype;
		a.resp.opaque = q.req.opaque;
		a.resp.data   = (q.req.mtype == MEM_READ) ? (q.req.addr ^ rd_key) : '0;
		return a;
	endfunction

	// ==================================================
	// reset, stimulus and bank models
	// ==================================================
	initial begin : stimulus
		logic [31:0] r;
		logic [1:0]  fire, bank_fire, resp_fire;
		net_req_t    taken [2];
		int          sent [2];
		int          cycles;
		logic        done;
		rst_n = 1'b0;
		mode = 1'b1;
		finish = 1'b0;
		req_in[0] = '0;
		req_in[1] = '0;
		resp_in[0] = '0;
		resp_in[1] = '0;
		req_in_domain = 2'b00;
		req_in_de_nsb = 2'b00;
		req_in_val = 2'b00;
		resp_out_rdy = 2'b00;
		req_out_rdy = 2'b00;
		resp_in_val = 2'b00;
		sent[0] = 0;
		sent[1] = 0;
		cycles = 0;
		done = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		while (!done && cycles < cycle_limit) begin
			@(negedge clk);
			fire      = req_in_val & req_in_rdy;
			bank_fire = req_out_val & req_out_rdy;
			resp_fire = resp_in_val & resp_in_rdy;
			taken[0]  = req_out[0];
			taken[1]  = req_out[1];
			@(posedge clk);
			#2;
			cycles++;
			// secure mode for the first half of the traffic
			mode = (sent[0] + sent[1]) < reqs_per_port;
			for (int p = 0; p < 2; p++) begin
				if (fire[p])
					req_in_val[p] = 1'b0;
				r = next_rand();
				resp_out_rdy[p] = r[31];
				if (!req_in_val[p] && sent[p] < reqs_per_port && r[30]) begin
					req_in[p].mtype  = mem_type_e'(r[29]);
					req_in[p].opaque = mem_opaque_t'(sent[p]);
					req_in[p].addr   = next_rand();
					req_in[p].data   = next_rand();
					// both ports fight for bank 0 in the second quarter
					if (sent[0] + sent[1] >= reqs_per_port / 2 && sent[0] + sent[1] < reqs_per_port)
						req_in[p].addr[`MEM_NET_BANK_BIT] = 1'b0;
					req_in_domain[p] = r[28];
					req_in_de_nsb[p] = r[27];
					req_in_val[p]    = 1'b1;
					sent[p]++;
				end
			end
			for (int b = 0; b < 2; b++) begin
				if (resp_fire[b])
					resp_in_val[b] = 1'b0;
				if (bank_fire[b]) begin
					resp_in[b]     = bank_answer(taken[b]);
					resp_in_val[b] = 1'b1;
				end
				r = next_rand();
				req_out_rdy[b] = r[31] && !resp_in_val[b];
			end
			done = (sent[0] + sent[1] == 2 * reqs_per_port) && req_in_val == 2'b00 && pending == 0;
		end
		finish = 1'b1;
		#1;
		if (!done)
			$display("timeout after %0d cycles with %0d requests still open", cycles, pending);
		if (done && err_total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/mem_net_checker.sv ====
/*
 * Memory network checker: predicts bank traffic and port responses for
 * every accepted request and compares them with what the DUT delivers
 */

`default_nettype none

`include "mem_net_config.svh"

module mem_net_checker
	import mem_msg_pkg::*;
	import net_msg_pkg::*;
#(
	parameter mem_data_t rd_key = '0
)
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       mode,
	input  logic       finish,
	input  mem_req_t   req_in [2],
	input  logic [1:0] req_in_domain,
	input  logic [1:0] req_in_de_nsb,
	input  logic [1:0] req_in_val,
	input  logic [1:0] req_in_rdy,
	input  mem_resp_t  resp_out [2],
	input  logic [1:0] resp_out_domain,
	input  logic [1:0] resp_out_fail,
	input  logic [1:0] resp_out_val,
	input  logic [1:0] resp_out_rdy,
	input  net_req_t   req_out [2],
	input  logic [1:0] req_out_val,
	input  logic [1:0] req_out_rdy,
	input  logic [1:0] resp_in_rdy,
	output int         pending,
	output int         err_total
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic      deny;
		net_req_t  at_bank;
		domain_t   domain;
		logic      fail;
		mem_resp_t resp;
	} expect_t;

	// open requests per port, granted requests per bank
	expect_t  port_q [2][$];
	net_req_t bank_q [2][$];
	int       mismatches = 0;
	int       unexpected = 0;
	int       reset_errs = 0;
	int       lost = 0;
	logic     seen_edge = 1'b0;

	assign err_total = mismatches + unexpected + reset_errs + lost;

	always @(posedge clk)
		seen_edge <= 1'b1;

	function automatic expect_t predict(mem_req_t r, domain_t dom, logic de_nsb,
			int src, logic secure);
		mem_addr_t lo_mask;
		mem_addr_t caddr;
		expect_t   e;
		// bits below the bank bit stay, bits above it drop by one place
		lo_mask = (mem_addr_t'(1) << `MEM_NET_BANK_BIT) - 1;
		caddr = (r.addr & lo_mask) | ((r.addr >> 1) & ~lo_mask);
		e.at_bank.dest     = r.addr[`MEM_NET_BANK_BIT];
		e.at_bank.src      = net_port_t'(src);
		e.at_bank.domain   = dom;
		e.at_bank.de_nsb   = de_nsb;
		e.at_bank.req      = r;
		e.at_bank.req.addr = caddr;
		e.deny        = secure && !dom && r.addr[`MEM_NET_BANK_BIT];
		e.domain      = dom;
		e.fail        = e.deny || caddr[3];
		e.resp.mtype  = r.mtype;
		e.resp.opaque = r.opaque;
		e.resp.data   = (e.deny || r.mtype == MEM_WRITE) ? '0 : caddr ^ rd_key;
		return e;
	endfunction

	// ==================================================
	// compare on the falling edge where handshakes are stable
	// ==================================================
	always @(negedge clk) begin : watch
		expect_t     e;
		net_req_t    got;
		logic [42:0] exp_r;
		logic [42:0] got_r;
		int          hit;
		if (!rst_n) begin
			if (seen_edge && (req_in_rdy !== 2'b00 || resp_out_val !== 2'b00 ||
					req_out_val !== 2'b00 || resp_in_rdy !== 2'b00)) begin
				$display("a val or rdy output is not low during reset at %0t", $time);
				reset_errs++;
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (req_in_val[p] && req_in_rdy[p]) begin
					e = predict(req_in[p], req_in_domain[p], req_in_de_nsb[p], p, mode);
					port_q[p].push_back(e);
					if (!e.deny)
						bank_q[e.at_bank.dest].push_back(e.at_bank);
				end
			end
			for (int b = 0; b < 2; b++) begin
				if (req_out_val[b] && req_out_rdy[b]) begin
					got = req_out[b];
					hit = -1;
					// oldest open request from the same port
					for (int i = bank_q[b].size() - 1; i >= 0; i--)
						if (bank_q[b][i].src == got.src)
							hit = i;
					if (hit < 0) begin
						$display("bank %0d got a request from port %0d that was not granted at %0t",
							b, got.src, $time);
						unexpected++;
					end else begin
						if (got !== bank_q[b][hit]) begin
							$display("ERR %0t req_out_p%0d exp %h got %h",
								$time, b, bank_q[b][hit], got);
							mismatches++;
						end
						bank_q[b].delete(hit);
					end
				end
			end
			for (int p = 0; p < 2; p++) begin
				if (resp_out_val[p] && resp_out_rdy[p]) begin
					got_r = {resp_out_domain[p], resp_out_fail[p], resp_out[p]};
					hit = -1;
					for (int i = port_q[p].size() - 1; i >= 0; i--)
						if (port_q[p][i].resp.opaque == resp_out[p].opaque)
							hit = i;
					if (hit < 0) begin
						$display("port %0d returned opaque %h with no open request at %0t",
							p, resp_out[p].opaque, $time);
						unexpected++;
					end else begin
						exp_r = {port_q[p][hit].domain, port_q[p][hit].fail, port_q[p][hit].resp};
						if (got_r !== exp_r) begin
							$display("ERR %0t resp_out_p%0d exp %h got %h", $time, p, exp_r, got_r);
							mismatches++;
						end
						port_q[p].delete(hit);
					end
				end
			end
		end
		pending = port_q[0].size() + port_q[1].size();
	end

	always @(posedge finish) begin : summary
		int missing;
		missing = bank_q[0].size() + bank_q[1].size();
		lost = port_q[0].size() + port_q[1].size() + missing;
		$display("errors: %0d mismatched, %0d unexpected, %0d unanswered, %0d not at bank, %0d reset",
			mismatches, unexpected, port_q[0].size() + port_q[1].size(), missing,
			reset_errs);
	end

endmodule

`default_nettype wire

// ==== design/mem_net_top.sv ====
/*
 * Secure memory network: two processor ports, two banks, a request ring
 * and a response ring with access control at the processor side
 */

`default_nettype none

module mem_net_top
	import mem_msg_pkg::*;
	import net_msg_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      mode,

	// processor side
	input  mem_req_t  req_in_p0,
	input  domain_t   req_in_domain_p0,
	input  logic      req_in_de_nsb_p0,
	input  logic      req_in_val_p0,
	output logic      req_in_rdy_p0,
	output mem_resp_t resp_out_p0,
	output domain_t   resp_out_domain_p0,
	output logic      resp_out_fail_p0,
	output logic      resp_out_val_p0,
	input  logic      resp_out_rdy_p0,

	input  mem_req_t  req_in_p1,
	input  domain_t   req_in_domain_p1,
	input  logic      req_in_de_nsb_p1,
	input  logic      req_in_val_p1,
	output logic      req_in_rdy_p1,
	output mem_resp_t resp_out_p1,
	output domain_t   resp_out_domain_p1,
	output logic      resp_out_fail_p1,
	output logic      resp_out_val_p1,
	input  logic      resp_out_rdy_p1,

	// bank side
	output net_req_t  req_out_p0,
	output logic      req_out_val_p0,
	input  logic      req_out_rdy_p0,
	input  net_resp_t resp_in_p0,
	input  logic      resp_in_val_p0,
	output logic      resp_in_rdy_p0,

	output net_req_t  req_out_p1,
	output logic      req_out_val_p1,
	input  logic      req_out_rdy_p1,
	input  net_resp_t resp_in_p1,
	input  logic      resp_in_val_p1,
	output logic      resp_in_rdy_p1
);

	net_req_t  net_req_p0, net_req_p1;
	net_resp_t ring_resp_p0, ring_resp_p1;
	logic      inj_val_p0, inj_val_p1, inj_rdy_p0, inj_rdy_p1;
	logic      ring_val_p0, ring_val_p1, ring_rdy_p0, ring_rdy_p1;

	mem_port_adapter #(.p_src(0)) adapter_p0 (
		.req     (req_in_p0),
		.domain  (req_in_domain_p0),
		.de_nsb  (req_in_de_nsb_p0),
		.net_req (net_req_p0)
	);

	mem_port_adapter #(.p_src(1)) adapter_p1 (
		.req     (req_in_p1),
		.domain  (req_in_domain_p1),
		.de_nsb  (req_in_de_nsb_p1),
		.net_req (net_req_p1)
	);

	mem_access_ctrl access_ctrl (
		.clk                (clk),
		.rst_n              (rst_n),
		.mode               (mode),
		.net_req_p0         (net_req_p0),
		.net_req_p1         (net_req_p1),
		.req_val_p0         (req_in_val_p0),
		.req_val_p1         (req_in_val_p1),
		.req_rdy_p0         (req_in_rdy_p0),
		.req_rdy_p1         (req_in_rdy_p1),
		.inj_val_p0         (inj_val_p0),
		.inj_val_p1         (inj_val_p1),
		.inj_rdy_p0         (inj_rdy_p0),
		.inj_rdy_p1         (inj_rdy_p1),
		.ring_resp_p0       (ring_resp_p0),
		.ring_resp_p1       (ring_resp_p1),
		.ring_val_p0        (ring_val_p0),
		.ring_val_p1        (ring_val_p1),
		.ring_rdy_p0        (ring_rdy_p0),
		.ring_rdy_p1        (ring_rdy_p1),
		.resp_out_p0        (resp_out_p0),
		.resp_out_p1        (resp_out_p1),
		.resp_out_domain_p0 (resp_out_domain_p0),
		.resp_out_domain_p1 (resp_out_domain_p1),
		.resp_out_fail_p0   (resp_out_fail_p0),
		.resp_out_fail_p1   (resp_out_fail_p1),
		.resp_out_val_p0    (resp_out_val_p0),
		.resp_out_val_p1    (resp_out_val_p1),
		.resp_out_rdy_p0    (resp_out_rdy_p0),
		.resp_out_rdy_p1    (resp_out_rdy_p1)
	);

	ring_net #(.msg_t(net_req_t)) req_ring (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_msg_p0  (net_req_p0),
		.in_val_p0  (inj_val_p0),
		.in_rdy_p0  (inj_rdy_p0),
		.out_msg_p0 (req_out_p0),
		.out_val_p0 (req_out_val_p0),
		.out_rdy_p0 (req_out_rdy_p0),
		.in_msg_p1  (net_req_p1),
		.in_val_p1  (inj_val_p1),
		.in_rdy_p1  (inj_rdy_p1),
		.out_msg_p1 (req_out_p1),
		.out_val_p1 (req_out_val_p1),
		.out_rdy_p1 (req_out_rdy_p1)
	);

	ring_net #(.msg_t(net_resp_t)) resp_ring (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_msg_p0  (resp_in_p0),
		.in_val_p0  (resp_in_val_p0),
		.in_rdy_p0  (resp_in_rdy_p0),
		.out_msg_p0 (ring_resp_p0),
		.out_val_p0 (ring_val_p0),
		.out_rdy_p0 (ring_rdy_p0),
		.in_msg_p1  (resp_in_p1),
		.in_val_p1  (resp_in_val_p1),
		.in_rdy_p1  (resp_in_rdy_p1),
		.out_msg_p1 (ring_resp_p1),
		.out_val_p1 (ring_val_p1),
		.out_rdy_p1 (ring_rdy_p1)
	);

endmodule

`default_nettype wire

// ==== design/ring_net.sv ====
/*
 * Two-port ring: one registered output stop per port, round-robin
 * arbitration when both inputs go to the same stop
 */

`default_nettype none

module ring_net
	import net_msg_pkg::*;
#(
	parameter type msg_t = net_req_t
)
(
	input  logic clk,
	input  logic rst_n,

	input  msg_t in_msg_p0,
	input  logic in_val_p0,
	output logic in_rdy_p0,
	output msg_t out_msg_p0,
	output logic out_val_p0,
	input  logic out_rdy_p0,

	input  msg_t in_msg_p1,
	input  logic in_val_p1,
	output logic in_rdy_p1,
	output msg_t out_msg_p1,
	output logic out_val_p1,
	input  logic out_rdy_p1
);

	msg_t            in_msg [2];
	msg_t            stop_msg [2];
	logic [1:0]      in_val, in_rdy, out_rdy;
	logic [1:0]      full, can_load, ptr;
	// indexed [stop][input]
	logic [1:0][1:0] req, gnt;

	assign in_msg[0] = in_msg_p0;
	assign in_msg[1] = in_msg_p1;
	assign in_val    = {in_val_p1, in_val_p0};
	assign out_rdy   = {out_rdy_p1, out_rdy_p0};

	assign {in_rdy_p1, in_rdy_p0} = in_rdy;
	assign {out_val_p1, out_val_p0} = full;
	assign out_msg_p0 = stop_msg[0];
	assign out_msg_p1 = stop_msg[1];

	// ==================================================
	// routing and arbitration
	// ==================================================
	always_comb begin
		for (int d = 0; d < 2; d++) begin
			can_load[d] = !full[d] || out_rdy[d];
			for (int i = 0; i < 2; i++)
				req[d][i] = in_val[i] && (in_msg[i].dest == net_port_t'(d));
			gnt[d] = 2'b00;
			if (can_load[d]) begin
				if (req[d] == 2'b11)
					gnt[d][ptr[d]] = 1'b1;
				else
					gnt[d] = req[d];
			end
		end
		in_rdy = gnt[0] | gnt[1];
	end

	// ==================================================
	// output stops
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full <= 2'b00;
			ptr  <= 2'b00;
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (can_load[d])
					full[d] <= |gnt[d];
				// contested grant hands priority to the loser
				if (can_load[d] && req[d] == 2'b11)
					ptr[d] <= ~ptr[d];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int d = 0; d < 2; d++) begin
			if (can_load[d] && |gnt[d])
				stop_msg[d] <= gnt[d][1] ? in_msg[1] : in_msg[0];
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_access_ctrl.sv ====
/*
 * Access control: denies domain 0 requests to bank 1 in secure mode
 * and answers them locally with a fail response
 */

`default_nettype none

module mem_access_ctrl
	import mem_msg_pkg::*;
	import net_msg_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      mode,

	input  net_req_t  net_req_p0,
	input  net_req_t  net_req_p1,
	input  logic      req_val_p0,
	input  logic      req_val_p1,
	output logic      req_rdy_p0,
	output logic      req_rdy_p1,

	output logic      inj_val_p0,
	output logic      inj_val_p1,
	input  logic      inj_rdy_p0,
	input  logic      inj_rdy_p1,

	input  net_resp_t ring_resp_p0,
	input  net_resp_t ring_resp_p1,
	input  logic      ring_val_p0,
	input  logic      ring_val_p1,
	output logic      ring_rdy_p0,
	output logic      ring_rdy_p1,

	output mem_resp_t resp_out_p0,
	output mem_resp_t resp_out_p1,
	output domain_t   resp_out_domain_p0,
	output domain_t   resp_out_domain_p1,
	output logic      resp_out_fail_p0,
	output logic      resp_out_fail_p1,
	output logic      resp_out_val_p0,
	output logic      resp_out_val_p1,
	input  logic      resp_out_rdy_p0,
	input  logic      resp_out_rdy_p1
);

	typedef enum logic {
		ST_IDLE,
		ST_FAIL_PEND
	} state_e;

	net_req_t   net_req [2];
	net_resp_t  ring_resp [2];
	mem_resp_t  out_resp [2];
	mem_resp_t  fail_resp [2];
	domain_t    out_dom [2];
	domain_t    fail_dom [2];
	state_e     state [2];
	logic [1:0] req_val, req_rdy, inj_val, inj_rdy;
	logic [1:0] ring_val, ring_rdy, out_val, out_rdy, out_fail;
	logic [1:0] deny, deny_acc;

	// ==================================================
	// port mapping
	// ==================================================
	assign net_req[0]   = net_req_p0;
	assign net_req[1]   = net_req_p1;
	assign ring_resp[0] = ring_resp_p0;
	assign ring_resp[1] = ring_resp_p1;
	assign req_val      = {req_val_p1, req_val_p0};
	assign inj_rdy      = {inj_rdy_p1, inj_rdy_p0};
	assign ring_val     = {ring_val_p1, ring_val_p0};
	assign out_rdy      = {resp_out_rdy_p1, resp_out_rdy_p0};

	assign {req_rdy_p1, req_rdy_p0}             = req_rdy;
	assign {inj_val_p1, inj_val_p0}             = inj_val;
	assign {ring_rdy_p1, ring_rdy_p0}           = ring_rdy;
	assign {resp_out_val_p1, resp_out_val_p0}   = out_val;
	assign {resp_out_fail_p1, resp_out_fail_p0} = out_fail;
	assign resp_out_p0        = out_resp[0];
	assign resp_out_p1        = out_resp[1];
	assign resp_out_domain_p0 = out_dom[0];
	assign resp_out_domain_p1 = out_dom[1];

	// ==================================================
	// per-port request gating and response mux
	// ==================================================
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			deny[p] = mode && (net_req[p].domain == 1'b0) && (net_req[p].dest == 1'b1);
			deny_acc[p] = (state[p] == ST_IDLE) && req_val[p] && deny[p];
			if (state[p] == ST_FAIL_PEND) begin
				// local fail response wins, ring stalls
				inj_val[p]  = 1'b0;
				req_rdy[p]  = 1'b0;
				ring_rdy[p] = 1'b0;
				out_resp[p] = fail_resp[p];
				out_dom[p]  = fail_dom[p];
				out_fail[p] = 1'b1;
				out_val[p]  = 1'b1;
			end else begin
				inj_val[p]  = req_val[p] && !deny[p];
				req_rdy[p]  = deny[p] ? req_val[p] : inj_rdy[p];
				ring_rdy[p] = out_rdy[p];
				out_resp[p] = ring_resp[p].resp;
				out_dom[p]  = ring_resp[p].domain;
				out_fail[p] = ring_resp[p].fail;
				out_val[p]  = ring_val[p];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (!rst_n) begin
				state[p] <= ST_IDLE;
			end else if (deny_acc[p]) begin
				state[p] <= ST_FAIL_PEND;
			end else if (state[p] == ST_FAIL_PEND && out_rdy[p]) begin
				state[p] <= ST_IDLE;
			end
		end
	end

	// fail response keeps type and tag of the denied request
	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (deny_acc[p]) begin
				fail_resp[p].mtype  <= net_req[p].req.mtype;
				fail_resp[p].opaque <= net_req[p].req.opaque;
				fail_resp[p].data   <= '0;
				fail_dom[p]         <= net_req[p].domain;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_port_adapter.sv ====
/*
 * Memory port adapter: wraps a memory request into a network request,
 * picks the bank from one address bit and squeezes that bit out
 */

`default_nettype none

`include "mem_net_config.svh"

module mem_port_adapter
	import mem_msg_pkg::*;
	import net_msg_pkg::*;
#(
	parameter int unsigned p_src = 0
)
(
	input  mem_req_t req,
	input  domain_t  domain,
	input  logic     de_nsb,
	output net_req_t net_req
);

	mem_addr_t addr_c;

	// upper bits move down one place to fill the bank bit
	assign addr_c = {1'b0,
		req.addr[`MEM_NET_ADDR_NBITS-1:`MEM_NET_BANK_BIT+1],
		req.addr[`MEM_NET_BANK_BIT-1:0]};

	always_comb begin
		net_req.dest     = req.addr[`MEM_NET_BANK_BIT];
		net_req.src      = net_port_t'(p_src);
		net_req.domain   = domain;
		net_req.de_nsb   = de_nsb;
		net_req.req      = req;
		net_req.req.addr = addr_c;
	end

endmodule

`default_nettype wire

// ==== design/net_msg_pkg.sv ====
/*
 * Network message package: ring messages with routing and security fields
 */

`default_nettype none

package net_msg_pkg;

	import mem_msg_pkg::*;

	// port number on the processor side, bank number on the memory side
	typedef logic net_port_t;
	typedef logic domain_t;

	typedef struct packed {
		net_port_t dest;
		net_port_t src;
		domain_t   domain;
		logic      de_nsb;
		mem_req_t  req;
	} net_req_t;

	// dest is copied from the src of the request by the bank
	typedef struct packed {
		net_port_t dest;
		domain_t   domain;
		logic      fail;
		mem_resp_t resp;
	} net_resp_t;

endpackage

`default_nettype wire

// ==== design/mem_msg_pkg.sv ====
/*
 * Memory message package: processor-side request and response types
 */

`default_nettype none

`include "mem_net_config.svh"

package mem_msg_pkg;

	typedef logic [`MEM_NET_ADDR_NBITS-1:0]   mem_addr_t;
	typedef logic [`MEM_NET_DATA_NBITS-1:0]   mem_data_t;
	typedef logic [`MEM_NET_OPAQUE_NBITS-1:0] mem_opaque_t;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_e;

	typedef struct packed {
		mem_type_e   mtype;
		mem_opaque_t opaque;
		mem_addr_t   addr;
		mem_data_t   data;
	} mem_req_t;

	// no address field, the opaque tag pairs it with its request
	typedef struct packed {
		mem_type_e   mtype;
		mem_opaque_t opaque;
		mem_data_t   data;
	} mem_resp_t;

endpackage

`default_nettype wire

// ==== include/mem_net_config.svh ====
/*
 * Memory network configuration: message field widths and bank select bit
 */

`ifndef MEM_NET_CONFIG_SVH
`define MEM_NET_CONFIG_SVH

// memory message field widths
`define MEM_NET_ADDR_NBITS   32
`define MEM_NET_DATA_NBITS   32
`define MEM_NET_OPAQUE_NBITS 8

// address bit that picks bank 0 or bank 1
`define MEM_NET_BANK_BIT     12

`endif
